// File: bnn_classifier.f
logic/bnn_pkg.sv
logic/bnn_weight_regs.sv
logic/bnn_hidden_layer.sv
logic/bnn_class_scores.sv
logic/bnn_argmax.sv
logic/bnn_classifier.sv
tb/bnn_classifier_chk.sv
tb/bnn_classifier_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bnn_classifier_tb
FILELIST  ?= bnn_classifier.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/bnn_classifier_tb.sv
`timescale 1ns/1ns
`default_nettype none

module bnn_classifier_tb;

    typedef logic [bnn_pkg::FEAT_CNT*bnn_pkg::FEAT_BITS-1:0] feats_t;

    logic                           clk;
    logic                           arst_n;
    bnn_pkg::cfg_write_t            cfg;
    bnn_pkg::feat_vec_t             sample_in;
    logic                           result_valid;
    logic [bnn_pkg::CLASS_BITS-1:0] prediction;

    // Model copy of the programmed weights
    logic [bnn_pkg::FEAT_CNT-1:0]   hid_w [bnn_pkg::HIDDEN_CNT];
    logic [bnn_pkg::HIDDEN_CNT-1:0] cls_w [bnn_pkg::CLASS_CNT];

    int    exp_q [$];
    int    seed;
    int    errors;
    int    checked;
    int    tests_run;
    int    tests_failed;
    string test_name;

    bnn_classifier dut0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .cfg          (cfg),
        .sample_in    (sample_in),
        .result_valid (result_valid),
        .prediction   (prediction)
    );

    always #2 clk = ~clk;

    // Integer reference of the network
    function automatic int predict(input feats_t feats);
        int          acc;
        int          score;
        int          best;
        int          best_score;
        logic [bnn_pkg::HIDDEN_CNT-1:0] fire;
        fire = '0;
        for (int n = 0; n < bnn_pkg::HIDDEN_CNT; n++) begin
            acc = 0;
            for (int f = 0; f < bnn_pkg::FEAT_CNT; f++) begin
                if (hid_w[n][f]) begin
                    acc = acc + int'(feats[f*bnn_pkg::FEAT_BITS +: bnn_pkg::FEAT_BITS]);
                end else begin
                    acc = acc - int'(feats[f*bnn_pkg::FEAT_BITS +: bnn_pkg::FEAT_BITS]);
                end
            end
            fire[n] = (acc >= 0);
        end
        best       = 0;
        best_score = -1;
        for (int c = 0; c < bnn_pkg::CLASS_CNT; c++) begin
            score = 0;
            for (int h = 0; h < bnn_pkg::HIDDEN_CNT; h++) begin
                if (fire[h] == cls_w[c][h]) begin
                    score++;
                end
            end
            if (score > best_score) begin  // Lowest index keeps ties
                best_score = score;
                best       = c;
            end
        end
        return best;
    endfunction

    function automatic logic [bnn_pkg::HIDDEN_CNT-1:0] rand_data();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[bnn_pkg::HIDDEN_CNT-1:0];
    endfunction

    function automatic feats_t rand_feats();
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        return r[$bits(feats_t)-1:0];
    endfunction

    task automatic write_row(input int row, input logic [bnn_pkg::HIDDEN_CNT-1:0] data);
        cfg.wr   = 1'b1;
        cfg.row  = bnn_pkg::ROW_BITS'(row);
        cfg.data = data;
        if (row < bnn_pkg::HIDDEN_CNT) begin
            hid_w[row] = data[bnn_pkg::FEAT_CNT-1:0];
        end else if (row < bnn_pkg::HIDDEN_CNT + bnn_pkg::CLASS_CNT) begin
            cls_w[row - bnn_pkg::HIDDEN_CNT] = data;
        end
        @(negedge clk);
        cfg.wr = 1'b0;
    endtask

    task automatic send_sample(input feats_t feats);
        sample_in.valid = 1'b1;
        sample_in.feats = feats;
        exp_q.push_back(predict(feats));
        @(negedge clk);
        sample_in.valid = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout in %s, %0d results never arrived", test_name, exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic finish_test(input int base);
        tests_run++;
        if (errors == base) begin
            $display("%s: done, no errors", test_name);
        end else begin
            tests_failed++;
            $display("%s: done, %0d errors", test_name, errors - base);
        end
    endtask

    // Outputs only move on posedge, so the falling edge sees them settled
    always @(negedge clk) begin
        int exp_cls;
        if (arst_n && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("Result appeared in %s with no sample pending", test_name);
                errors++;
            end else begin
                exp_cls = exp_q.pop_front();
                checked++;
                assert (int'(prediction) == exp_cls) else begin
                    $display("FAILED %s expected %0d actual %0d", test_name, exp_cls,
                             prediction);
                    errors++;
                end
            end
        end
    end

    initial begin
        int base;
        int gap;
        clk          = 1'b0;
        arst_n       = 1'b0;
        cfg          = '0;
        sample_in    = '0;
        seed         = 32'he9b4_7660;
        errors       = 0;
        checked      = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int n = 0; n < bnn_pkg::HIDDEN_CNT; n++) begin
            hid_w[n] = '0;
        end
        for (int c = 0; c < bnn_pkg::CLASS_CNT; c++) begin
            cls_w[c] = '0;
        end
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Zero weights, all classes tie so class 0 wins
        test_name = "reset_state";
        base      = errors;
        send_sample('0);
        for (int i = 0; i < 15; i++) begin
            send_sample(rand_feats());
        end
        wait_drain();
        finish_test(base);

        test_name = "dominant_class";
        base      = errors;
        for (int n = 0; n < bnn_pkg::HIDDEN_CNT; n++) begin
            write_row(n, '1);
        end
        for (int c = 0; c < bnn_pkg::CLASS_CNT; c++) begin
            write_row(bnn_pkg::HIDDEN_CNT + c, (c == 5) ? '1 : '0);
        end
        for (int i = 0; i < 20; i++) begin
            send_sample(rand_feats());
        end
        wait_drain();
        finish_test(base);

        // Every neuron still fires, rows 2 and 4 share the top score
        test_name = "tie_break";
        base      = errors;
        for (int c = 0; c < bnn_pkg::CLASS_CNT; c++) begin
            if (c == 2 || c == 4) begin
                write_row(bnn_pkg::HIDDEN_CNT + c, 40'h00_ffff_ffff);
            end else begin
                write_row(bnn_pkg::HIDDEN_CNT + c, rand_data() & 40'h00_0000_ffff);
            end
        end
        for (int i = 0; i < 20; i++) begin
            send_sample(rand_feats());
        end
        wait_drain();
        finish_test(base);

        test_name = "random_network";
        base      = errors;
        for (int r = 0; r < bnn_pkg::HIDDEN_CNT + bnn_pkg::CLASS_CNT; r++) begin
            write_row(r, rand_data());
        end
        for (int r = bnn_pkg::HIDDEN_CNT + bnn_pkg::CLASS_CNT; r < 64; r++) begin
            write_row(r, rand_data());  // Unused rows, must not alias
        end
        for (int i = 0; i < 200; i++) begin
            send_sample(rand_feats());
        end
        wait_drain();
        finish_test(base);

        test_name = "stream_gaps";
        base      = errors;
        for (int i = 0; i < 60; i++) begin
            send_sample(rand_feats());
            gap = {$random(seed)} % 5;
            repeat (gap) @(negedge clk);
        end
        wait_drain();
        finish_test(base);

        $display("Tests %0d, failed %0d, results checked %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, checked, errors, dut0.chk0.err_cnt);
        if (errors == 0 && dut0.chk0.err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/bnn_classifier_chk.sv
`timescale 1ns/1ns
`default_nettype none

module bnn_classifier_chk (
    input wire logic                           clk,
    input wire logic                           arst_n,
    input wire bnn_pkg::feat_vec_t             sample_in,
    input wire logic                           result_valid,
    input wire logic [bnn_pkg::CLASS_BITS-1:0] prediction
);

    int err_cnt = 0;

    // Three registered stages, no drops and no extra results
    latency_a: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid == $past(sample_in.valid, 3))
        else begin
            $error("result_valid does not follow sample_in.valid by 3 cycles");
            err_cnt++;
        end

    reset_a: assert property (@(posedge clk) !arst_n |-> !result_valid)
        else begin
            $error("result_valid high during reset");
            err_cnt++;
        end

    range_a: assert property (@(posedge clk) disable iff (!arst_n)
        result_valid |-> int'(prediction) < bnn_pkg::CLASS_CNT)
        else begin
            $error("prediction out of class range");
            err_cnt++;
        end

    // Held between results
    hold_a: assert property (@(posedge clk) disable iff (!arst_n)
        !result_valid |-> $stable(prediction))
        else begin
            $error("prediction changed without result_valid");
            err_cnt++;
        end

endmodule

bind bnn_classifier bnn_classifier_chk chk0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .sample_in    (sample_in),
    .result_valid (result_valid),
    .prediction   (prediction)
);

`default_nettype wire

// File: logic/bnn_classifier.sv
`timescale 1ns/1ns
`default_nettype none

module bnn_classifier (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire bnn_pkg::cfg_write_t       cfg,
    input  wire bnn_pkg::feat_vec_t        sample_in,
    output logic                           result_valid,
    output logic [bnn_pkg::CLASS_BITS-1:0] prediction
);

    bnn_pkg::hidden_wts_t hidden_wts;
    bnn_pkg::class_wts_t  class_wts;
    bnn_pkg::hidden_vec_t hidden_vec;
    bnn_pkg::score_vec_t  score_vec;

    bnn_weight_regs weights0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg        (cfg),
        .hidden_wts (hidden_wts),
        .class_wts  (class_wts)
    );

    // Three registered stages, fixed latency of 3
    bnn_hidden_layer hidden0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .sample_in  (sample_in),
        .hidden_wts (hidden_wts),
        .hidden_out (hidden_vec)
    );

    bnn_class_scores scores0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .hidden_in  (hidden_vec),
        .class_wts  (class_wts),
        .scores_out (score_vec)
    );

    bnn_argmax argmax0 (
        .clk          (clk),
        .arst_n       (arst_n),
        .scores_in    (score_vec),
        .result_valid (result_valid),
        .prediction   (prediction)
    );

endmodule

`default_nettype wire

// File: logic/bnn_argmax.sv
`timescale 1ns/1ns
`default_nettype none

module bnn_argmax (
    input  wire logic                       clk,
    input  wire logic                       arst_n,
    input  wire bnn_pkg::score_vec_t        scores_in,
    output logic                            result_valid,
    output logic [bnn_pkg::CLASS_BITS-1:0]  prediction
);

    logic [bnn_pkg::SUM_BITS-1:0]   best_score;
    logic [bnn_pkg::CLASS_BITS-1:0] best_idx;

    // Ascending scan, strictly greater wins so ties keep the lower index
    always_comb begin
        best_score = scores_in.score[0];
        best_idx   = '0;
        for (int c = 1; c < bnn_pkg::CLASS_CNT; c++) begin
            if (scores_in.score[c] > best_score) begin
                best_score = scores_in.score[c];
                best_idx   = bnn_pkg::CLASS_BITS'(c);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_valid <= 1'b0;
            prediction   <= '0;
        end else begin
            result_valid <= scores_in.valid;
            if (scores_in.valid) begin
                prediction <= best_idx;  // Held until the next result
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/bnn_class_scores.sv
`timescale 1ns/1ns
`default_nettype none

module bnn_class_scores (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire bnn_pkg::hidden_vec_t hidden_in,
    input  wire bnn_pkg::class_wts_t  class_wts,
    output bnn_pkg::score_vec_t       scores_out
);

    logic [bnn_pkg::HIDDEN_CNT-1:0]                  agree;
    logic [bnn_pkg::CLASS_CNT-1:0][bnn_pkg::SUM_BITS-1:0] score;
    logic [bnn_pkg::CLASS_CNT-1:0][bnn_pkg::SUM_BITS-1:0] score_q;
    logic                                            valid_q;

    // XNOR against each class row, then popcount
    always_comb begin
        agree = '0;
        score = '0;
        for (int c = 0; c < bnn_pkg::CLASS_CNT; c++) begin
            agree = ~(hidden_in.bits ^ class_wts[c]);
            for (int h = 0; h < bnn_pkg::HIDDEN_CNT; h++) begin
                score[c] = score[c] + bnn_pkg::SUM_BITS'(agree[h]);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= hidden_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        score_q <= score;
    end

    assign scores_out = '{valid: valid_q, score: score_q};

endmodule

`default_nettype wire

// File: logic/bnn_hidden_layer.sv
`timescale 1ns/1ns
`default_nettype none

module bnn_hidden_layer (
    input  wire logic                 clk,
    input  wire logic                 arst_n,
    input  wire bnn_pkg::feat_vec_t   sample_in,
    input  wire bnn_pkg::hidden_wts_t hidden_wts,
    output bnn_pkg::hidden_vec_t      hidden_out
);

    logic signed [bnn_pkg::ACC_BITS:0]     acc;   // One spare bit, sums reach +-165
    logic signed [bnn_pkg::ACC_BITS:0]     feat;
    logic        [bnn_pkg::HIDDEN_CNT-1:0] fire;
    logic        [bnn_pkg::HIDDEN_CNT-1:0] fire_q;
    logic                                  valid_q;

    // Each neuron adds or subtracts every feature, then thresholds at zero
    always_comb begin
        acc  = '0;
        feat = '0;
        fire = '0;
        for (int n = 0; n < bnn_pkg::HIDDEN_CNT; n++) begin
            acc = '0;
            for (int f = 0; f < bnn_pkg::FEAT_CNT; f++) begin
                feat = '0;
                feat[bnn_pkg::FEAT_BITS-1:0] =
                    sample_in.feats[f*bnn_pkg::FEAT_BITS +: bnn_pkg::FEAT_BITS];
                if (hidden_wts[n][f]) begin
                    acc = acc + feat;
                end else begin
                    acc = acc - feat;
                end
            end
            fire[n] = ~acc[bnn_pkg::ACC_BITS];  // Sum >= 0
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= sample_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        fire_q <= fire;
    end

    assign hidden_out = '{valid: valid_q, bits: fire_q};

endmodule

`default_nettype wire

// File: logic/bnn_weight_regs.sv
`timescale 1ns/1ns
`default_nettype none

module bnn_weight_regs (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire bnn_pkg::cfg_write_t cfg,
    output bnn_pkg::hidden_wts_t     hidden_wts,
    output bnn_pkg::class_wts_t      class_wts
);

    logic [bnn_pkg::ROW_BITS-1:0] hid_row;
    logic [bnn_pkg::ROW_BITS-1:0] cls_row;
    logic                         hid_sel;
    logic                         cls_sel;

    // Offsets into each region
    assign hid_row = cfg.row - bnn_pkg::ROW_HIDDEN_BASE;
    assign cls_row = cfg.row - bnn_pkg::ROW_CLASS_BASE;

    assign hid_sel = cfg.wr && (cfg.row < bnn_pkg::ROW_CLASS_BASE);
    assign cls_sel = cfg.wr && (cfg.row >= bnn_pkg::ROW_CLASS_BASE)
                     && (cls_row < bnn_pkg::CLASS_CNT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hidden_wts <= '0;
        end else if (hid_sel) begin
            hidden_wts[hid_row] <= cfg.data[bnn_pkg::FEAT_CNT-1:0];  // Low 11 bits only
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            class_wts <= '0;
        end else if (cls_sel) begin
            class_wts[cls_row[bnn_pkg::CLASS_BITS-1:0]] <= cfg.data;
        end
    end

endmodule

`default_nettype wire

// File: logic/bnn_pkg.sv
`default_nettype none

package bnn_pkg;

    localparam int FEAT_CNT   = 11;
    localparam int FEAT_BITS  = 4;
    localparam int HIDDEN_CNT = 40;
    localparam int CLASS_CNT  = 7;
    localparam int SUM_BITS   = 6;   // Class score, 0 to 40
    localparam int CLASS_BITS = 3;
    localparam int ROW_BITS   = 6;
    localparam int ACC_BITS   = 8;   // Neuron sum, -165 to +165

    typedef struct packed {
        logic                          valid;
        logic [FEAT_CNT*FEAT_BITS-1:0] feats;  // Feature 0 in the low nibble
    } feat_vec_t;

    typedef struct packed {
        logic                  valid;
        logic [HIDDEN_CNT-1:0] bits;
    } hidden_vec_t;

    typedef struct packed {
        logic                               valid;
        logic [CLASS_CNT-1:0][SUM_BITS-1:0] score;
    } score_vec_t;

    typedef struct packed {
        logic                  wr;
        logic [ROW_BITS-1:0]   row;
        logic [HIDDEN_CNT-1:0] data;
    } cfg_write_t;

    typedef logic [HIDDEN_CNT-1:0][FEAT_CNT-1:0] hidden_wts_t;
    typedef logic [CLASS_CNT-1:0][HIDDEN_CNT-1:0] class_wts_t;

    // Row map of the config port, rows past the class region are dropped
    typedef enum logic [ROW_BITS-1:0] {
        ROW_HIDDEN_BASE = 0,
        ROW_CLASS_BASE  = 40
    } cfg_row_e;

endpackage

`default_nettype wire
